//--- Makefile
# Verilator build and run of the sprite compositor testbench

VERILATOR ?= verilator
TOP ?= spriteTb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= TB PASSED
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+test
logic/spritePkg.sv
logic/spanIf.sv
logic/spriteRegs.sv
logic/spriteFetch.sv
logic/pixelMerge.sv
logic/lineBuffer.sv
logic/spriteTop.sv
test/spriteTb.sv

//--- logic/lineBuffer.sv
`timescale 1ns/1ps

module lineBuffer import spritePkg::*; #(
	parameter int LineWords = 16
) (
	input logic clk,
	input logic reset,
	spanIf.sink span,
	input logic [$clog2(LineWords * 4)-1:0] scanAddr,
	output pixelT scanPixel
);

	localparam int WordBits = $clog2(LineWords);

	// Four pixels per word with lane 0 leftmost on the line
	pixelT [3:0] wordData [LineWords];
	logic [3:0] wordUpdated [LineWords];
	depthT [3:0] wordDepth [LineWords];

	pixelT [3:0] mergedData;
	logic [3:0] mergedUpdated;
	depthT [3:0] mergedDepth;

	logic [WordBits-1:0] scanWord;
	logic [1:0] scanLane;

	// Read side of the read modify write sees the word as of this cycle
	pixelMerge merge (
		.first(span.first),
		.offset(span.offset),
		.depth(span.depth),
		.palette(span.palette),
		.tileData(span.tileData),
		.previous(span.previous),
		.inData(wordData[span.wordAddr]),
		.inUpdated(wordUpdated[span.wordAddr]),
		.inDepth(wordDepth[span.wordAddr]),
		.outData(mergedData),
		.outUpdated(mergedUpdated),
		.outDepth(mergedDepth)
	);

	////////////////////
	// Updated flags
	always_ff @(posedge clk) begin
		if (reset || span.clearLine) begin
			for (int w = 0; w < LineWords; w++) begin
				wordUpdated[w] <= '0;
			end
		end else if (span.valid) begin
			wordUpdated[span.wordAddr] <= mergedUpdated;
		end
	end

	// Stale data and depth behind a cleared flag are never shown
	always_ff @(posedge clk) begin
		if (span.valid) begin
			wordData[span.wordAddr] <= mergedData;
			wordDepth[span.wordAddr] <= mergedDepth;
		end
	end

	////////////////////
	// Scan port
	assign scanWord = scanAddr[WordBits+1:2];
	assign scanLane = scanAddr[1:0];

	always_ff @(posedge clk) begin
		scanPixel <= wordUpdated[scanWord][scanLane] ? wordData[scanWord][scanLane] : '0;
	end

	// Fetch clips at the right edge so no beat may land past the line
	beatInsideLine: assert property (@(posedge clk) disable iff (reset)
		span.valid |-> (int'(span.wordAddr) < LineWords))
		else $error("merge beat beyond the end of the line");

endmodule

//--- logic/pixelMerge.sv
`timescale 1ns/1ps

module pixelMerge import spritePkg::*; (
	input logic first,
	input logic [1:0] offset,
	input depthT depth,
	input paletteT palette,
	input tileRowT tileData,
	input indexT [2:0] previous,
	input pixelT [3:0] inData,
	input logic [3:0] inUpdated,
	input depthT [3:0] inDepth,
	output pixelT [3:0] outData,
	output logic [3:0] outUpdated,
	output depthT [3:0] outDepth
);

	// Pixel stream F, G, H from the leftover then A through H of the row
	indexT stream [11];
	indexT [3:0] lanePixel;
	logic [3:0] laneTake;

	always_comb begin
		stream[0] = previous[0];
		stream[1] = previous[1];
		stream[2] = previous[2];
		for (int k = 0; k < 8; k++) begin
			stream[k + 3] = tileData[4 * k +: 4];
		end
	end

	////////////////////
	// Lane alignment
	// The first beat starts pixel A at lane offset with leftovers below it
	// The second beat continues four pixels further along the row
	always_comb begin
		for (int lane = 0; lane < 4; lane++) begin
			int pick;
			pick = 3 + lane - int'(offset) + (first ? 0 : 4);
			lanePixel[lane] = stream[pick];
		end
	end

	////////////////////
	// Depth priority
	always_comb begin
		for (int lane = 0; lane < 4; lane++) begin
			// An untouched lane takes anything, transparent pixels too
			// A written lane yields only to an opaque pixel with strictly higher depth
			laneTake[lane] = !inUpdated[lane] ||
				((lanePixel[lane] != '0) && (depth > inDepth[lane]));
			outUpdated[lane] = inUpdated[lane] || laneTake[lane];
			outDepth[lane] = laneTake[lane] ? depth : inDepth[lane];
			outData[lane] = laneTake[lane] ? {palette, lanePixel[lane]} : inData[lane];
		end
	end

endmodule

//--- logic/spanIf.sv
`timescale 1ns/1ps

interface spanIf import spritePkg::*; #(
	parameter int LineWords = 16
);

	// One merge beat into the line buffer, taken whenever valid is high
	logic valid;
	logic [$clog2(LineWords)-1:0] wordAddr;
	logic first;
	logic [1:0] offset;
	depthT depth;
	paletteT palette;
	tileRowT tileData;
	// Leftover pixels H, G and F of the row, with H in the top nibble
	indexT [2:0] previous;

	// Single cycle pulse that drops every updated flag of the line
	logic clearLine;

	modport source (output valid, wordAddr, first, offset, depth, palette, tileData, previous,
		clearLine);
	modport sink (input valid, wordAddr, first, offset, depth, palette, tileData, previous,
		clearLine);

endinterface

//--- logic/spriteFetch.sv
`timescale 1ns/1ps

module spriteFetch import spritePkg::*; #(
	parameter int SpriteCount = 8,
	parameter int TileCount = 16,
	parameter int LineWords = 16
) (
	input logic clk,
	input logic reset,
	input logic go,
	input lineT lineNumber,
	output logic [$clog2(SpriteCount)-1:0] spriteIndex,
	input attrT spriteAttr,
	output logic [$clog2(TileCount * 8)-1:0] tileAddr,
	input tileRowT tileRow,
	output logic busy,
	output logic donePulse,
	spanIf.source span
);

	localparam int IndexBits = $clog2(SpriteCount);
	localparam int TileAddrBits = $clog2(TileCount * 8);
	localparam int WordBits = $clog2(LineWords);

	fetchStateT state;
	fetchStateT stateNext;

	logic attrEnable;
	logic [3:0] attrTile;
	paletteT attrPalette;
	depthT attrDepth;
	lineT attrY;
	xPosT attrX;
	logic [8:0] lineDiff;
	logic hit;
	logic firstFits;
	logic secondFits;
	logic leftoverFits;
	logic lastSprite;
	logic spriteEnd;

	logic [3:0] baseWord;
	logic [1:0] baseOffset;
	depthT spriteDepth;
	paletteT spritePalette;
	tileRowT rowKeep;
	logic [1:0] beatStep;

	assign {attrEnable, attrTile, attrPalette, attrDepth, attrY, attrX} = spriteAttr;

	// Nine bit difference so a line above the sprite top goes negative and misses
	assign lineDiff = {1'b0, lineNumber} - {1'b0, attrY};
	assign hit = attrEnable && (lineDiff < 9'd8);

	// Row address stays put through the beats because the index only moves at sprite end
	assign tileAddr = TileAddrBits'({attrTile, lineDiff[2:0]});

	// Right edge clipping per beat
	assign firstFits = int'(attrX[5:2]) < LineWords;
	assign secondFits = int'(baseWord) + 1 < LineWords;
	assign leftoverFits = (baseOffset != 2'd0) && (int'(baseWord) + 2 < LineWords);
	assign lastSprite = spriteIndex == IndexBits'(SpriteCount - 1);

	////////////////////
	// Next state
	always_comb begin
		stateNext = state;
		spriteEnd = 1'b0;
		case (state)
			idle:
				if (go)
					stateNext = clear;
			clear:
				stateNext = lookup;
			lookup:
				if (hit && firstFits)
					stateNext = beatFirst;
				else
					spriteEnd = 1'b1;
			beatFirst:
				if (secondFits)
					stateNext = beatSecond;
				else
					spriteEnd = 1'b1;
			beatSecond:
				if (leftoverFits)
					stateNext = beatLeftover;
				else
					spriteEnd = 1'b1;
			beatLeftover:
				spriteEnd = 1'b1;
			done:
				stateNext = idle;
			default:
				stateNext = idle;
		endcase
		// Finishing a sprite moves on to the next slot or ends the line
		if (spriteEnd)
			stateNext = lastSprite ? done : lookup;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			busy <= 1'b0;
			donePulse <= 1'b0;
			spriteIndex <= '0;
		end else begin
			state <= stateNext;
			// Set by the start pulse and held until the walk leaves done
			busy <= go || (busy && state != done);
			// Rises on the same edge on which busy falls
			donePulse <= state == done;
			if (state == clear)
				spriteIndex <= '0;
			else if (spriteEnd && !lastSprite)
				spriteIndex <= spriteIndex + 1'b1;
		end
	end

	// Sprite placement is latched in lookup and the row arrives during the first beat
	always_ff @(posedge clk) begin
		if (state == lookup) begin
			baseWord <= attrX[5:2];
			baseOffset <= attrX[1:0];
			spriteDepth <= attrDepth;
			spritePalette <= attrPalette;
		end
		if (state == beatFirst)
			rowKeep <= tileRow;
	end

	////////////////////
	// Beat outputs
	always_comb begin
		span.valid = 1'b0;
		span.first = 1'b0;
		span.tileData = '0;
		span.previous = '0;
		beatStep = 2'd0;
		case (state)
			beatFirst: begin
				span.valid = 1'b1;
				span.first = 1'b1;
				span.tileData = tileRow;
			end
			beatSecond: begin
				span.valid = 1'b1;
				span.tileData = rowKeep;
				beatStep = 2'd1;
			end
			// Only H, G and F remain and the fresh row slot stays transparent
			beatLeftover: begin
				span.valid = 1'b1;
				span.first = 1'b1;
				span.previous = rowKeep[31:20];
				beatStep = 2'd2;
			end
			default: begin
				span.valid = 1'b0;
			end
		endcase
	end

	assign span.wordAddr = WordBits'(int'(baseWord) + int'(beatStep));
	assign span.offset = baseOffset;
	assign span.depth = spriteDepth;
	assign span.palette = spritePalette;
	assign span.clearLine = state == clear;

	busyOutsideIdle: assert property (@(posedge clk) disable iff (reset)
		busy == (state != idle))
		else $error("busy out of step with the fetch state");

endmodule

//--- logic/spritePkg.sv
package spritePkg;

	// Colour index of one tile pixel and index 0 is transparent
	typedef logic [3:0] indexT;
	typedef logic [4:0] paletteT;

	// Line pixel with the palette in bits 8:4 and the colour index in bits 3:0
	typedef logic [8:0] pixelT;

	// Sprite Z level where a higher value is closer to the viewer
	typedef logic [1:0] depthT;

	// Eight pixels of one tile row and pixel A sits in bits 3:0
	typedef logic [31:0] tileRowT;
	typedef logic [7:0] lineT;
	typedef logic [5:0] xPosT;

	// Attribute word layout from bit 25 down to bit 0
	// enable, tile 24:21, palette 20:16, depth 15:14, y top 13:6, x 5:0
	typedef logic [25:0] attrT;

	typedef logic [11:0] apbAddrT;
	typedef logic [31:0] apbDataT;

	typedef enum logic [2:0] {
		idle,
		clear,
		lookup,
		beatFirst,
		beatSecond,
		beatLeftover,
		done
	} fetchStateT;

	////////////////////
	// APB byte addresses and the two low address bits are ignored
	localparam apbAddrT ctrlAddr = 12'h000;
	localparam apbAddrT statusAddr = 12'h004;
	localparam apbAddrT lineAddr = 12'h008;
	// One attribute word per sprite slot
	localparam apbAddrT spriteBase = 12'h100;
	// One word per tile row so row r of tile t lives at tileBase + 32*t + 4*r
	localparam apbAddrT tileBase = 12'h400;

endpackage

//--- logic/spriteRegs.sv
`timescale 1ns/1ps

module spriteRegs import spritePkg::*; #(
	parameter int SpriteCount = 8,
	parameter int TileCount = 16
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apbAddrT paddr,
	input apbDataT pwdata,
	output apbDataT prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	input logic donePulse,
	output logic go,
	output lineT lineNumber,
	input logic [$clog2(SpriteCount)-1:0] spriteIndex,
	output attrT spriteAttr,
	input logic [$clog2(TileCount * 8)-1:0] tileAddr,
	output tileRowT tileRow
);

	localparam int IndexBits = $clog2(SpriteCount);
	localparam int TileAddrBits = $clog2(TileCount * 8);

	attrT attrMem [SpriteCount];
	tileRowT tileMem [TileCount * 8];

	logic access;
	logic readAccess;
	logic writeAccess;
	logic ctrlHit;
	logic statusHit;
	logic lineHit;
	logic spriteHit;
	logic tileHit;
	logic mapped;
	logic lockedWrite;
	logic doneFlag;
	apbAddrT spriteOffset;
	apbAddrT tileOffset;
	logic [IndexBits-1:0] spriteSlot;
	logic [TileAddrBits-1:0] tileSlot;
	apbDataT readData;

	////////////////////
	// Address decode
	assign access = psel && penable;
	assign readAccess = access && !pwrite;
	assign writeAccess = access && pwrite;

	assign ctrlHit = paddr[11:2] == ctrlAddr[11:2];
	assign statusHit = paddr[11:2] == statusAddr[11:2];
	assign lineHit = paddr[11:2] == lineAddr[11:2];

	// An address below a table base wraps to a large offset and misses the table
	assign spriteOffset = paddr - spriteBase;
	assign tileOffset = paddr - tileBase;
	assign spriteHit = spriteOffset < apbAddrT'(SpriteCount * 4);
	assign tileHit = tileOffset < apbAddrT'(TileCount * 32);
	assign spriteSlot = spriteOffset[IndexBits+1:2];
	assign tileSlot = tileOffset[TileAddrBits+1:2];

	assign mapped = ctrlHit || statusHit || lineHit || spriteHit || tileHit;

	// Tables and the line number are frozen while a compose runs
	assign lockedWrite = writeAccess && busy && (lineHit || spriteHit || tileHit);

	// Zero wait slave so every access phase completes at once
	assign pready = 1'b1;
	assign pslverr = access && (!mapped || lockedWrite);

	// Ctrl reads back as zero since the start bit clears itself
	always_comb begin
		readData = '0;
		if (statusHit)
			readData = {30'd0, doneFlag, busy};
		else if (lineHit)
			readData = {24'd0, lineNumber};
		else if (spriteHit)
			readData = apbDataT'(attrMem[spriteSlot]);
		else if (tileHit)
			readData = tileMem[tileSlot];
	end

	////////////////////
	// Control and status
	always_ff @(posedge clk) begin
		if (reset) begin
			go <= 1'b0;
			lineNumber <= '0;
			doneFlag <= 1'b0;
			prdata <= '0;
		end else begin
			// A start request while busy is dropped without an error
			go <= writeAccess && ctrlHit && pwdata[0] && !busy;
			if (writeAccess && lineHit && !busy)
				lineNumber <= pwdata[7:0];
			// A status read clears only a done flag that it returned
			// A new done wins over the clearing read of the same cycle
			doneFlag <= donePulse || (doneFlag && !(readAccess && statusHit && prdata[1]));
			// Read data is captured in the setup phase and held through the access phase
			if (psel && !penable)
				prdata <= pwrite ? '0 : readData;
		end
	end

	////////////////////
	// Attribute table and tile pattern memory
	always_ff @(posedge clk) begin
		if (writeAccess && !busy && spriteHit)
			attrMem[spriteSlot] <= pwdata[25:0];
		if (writeAccess && !busy && tileHit)
			tileMem[tileSlot] <= pwdata;
	end

	// The fetch side sees attributes at once and tile rows one cycle later
	assign spriteAttr = attrMem[spriteIndex];

	always_ff @(posedge clk) begin
		tileRow <= tileMem[tileAddr];
	end

	enableNeedsSelect: assert property (@(posedge clk) disable iff (reset) penable |-> psel)
		else $error("penable raised without psel");

endmodule

//--- logic/spriteTop.sv
`timescale 1ns/1ps

module spriteTop import spritePkg::*; #(
	parameter int SpriteCount = 8,
	parameter int TileCount = 16,
	parameter int LineWords = 16
) (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input apbAddrT paddr,
	input apbDataT pwdata,
	output apbDataT prdata,
	output logic pready,
	output logic pslverr,
	input logic [$clog2(LineWords * 4)-1:0] scanAddr,
	output pixelT scanPixel
);

	localparam int IndexBits = $clog2(SpriteCount);
	localparam int TileAddrBits = $clog2(TileCount * 8);

	logic go;
	logic busy;
	logic donePulse;
	lineT lineNumber;
	logic [IndexBits-1:0] spriteIndex;
	attrT spriteAttr;
	logic [TileAddrBits-1:0] tileAddr;
	tileRowT tileRow;

	spanIf #(.LineWords(LineWords)) span ();

	// Host side registers and tables
	spriteRegs #(
		.SpriteCount(SpriteCount),
		.TileCount(TileCount)
	) regs (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.busy(busy),
		.donePulse(donePulse),
		.go(go),
		.lineNumber(lineNumber),
		.spriteIndex(spriteIndex),
		.spriteAttr(spriteAttr),
		.tileAddr(tileAddr),
		.tileRow(tileRow)
	);

	// Sprite walk steered by the register block
	spriteFetch #(
		.SpriteCount(SpriteCount),
		.TileCount(TileCount),
		.LineWords(LineWords)
	) fetch (
		.clk(clk),
		.reset(reset),
		.go(go),
		.lineNumber(lineNumber),
		.spriteIndex(spriteIndex),
		.spriteAttr(spriteAttr),
		.tileAddr(tileAddr),
		.tileRow(tileRow),
		.busy(busy),
		.donePulse(donePulse),
		.span(span.source)
	);

	// Composed line and the display scan port
	lineBuffer #(
		.LineWords(LineWords)
	) buffer (
		.clk(clk),
		.reset(reset),
		.span(span.sink),
		.scanAddr(scanAddr),
		.scanPixel(scanPixel)
	);

endmodule

//--- test/spriteModel.svh
`ifndef SPRITE_MODEL_SVH
`define SPRITE_MODEL_SVH

// Expected scan value of every pixel and 0 where no beat touched the lane
pixelT modelPixel [PixelCount];

// Composes one line from attrCopy and tileCopy
// Beat b of a sprite covers word x/4 + b and its lane l shows row pixel 4*b + l - x%4
// Pixels outside A to H come out transparent, as the zero leftovers and the empty row slot do
function automatic void composeLine(input int lineNo);
	pixelT data [PixelCount];
	logic touched [PixelCount];
	depthT level [PixelCount];
	attrT a;
	tileRowT row;
	indexT idx;
	int s;
	int b;
	int lane;
	int p;
	int pos;
	int word;
	int off;
	int diff;
	for (pos = 0; pos < PixelCount; pos++) begin
		data[pos] = '0;
		touched[pos] = 1'b0;
		level[pos] = '0;
	end
	for (s = 0; s < SpriteCount; s++) begin
		a = attrCopy[s];
		diff = lineNo - int'(a[13:6]);
		if (a[25] && diff >= 0 && diff < 8) begin
			row = tileCopy[int'(a[24:21]) * 8 + diff];
			word = int'(a[5:0]) / 4;
			off = int'(a[5:0]) % 4;
			for (b = 0; b < 3; b++) begin
				// The third beat exists only for a misaligned sprite, and nothing past the edge
				if ((b < 2 || off != 0) && word + b < LineWords) begin
					for (lane = 0; lane < 4; lane++) begin
						p = 4 * b + lane - off;
						if (p >= 0 && p < 8)
							idx = row[4 * p +: 4];
						else
							idx = '0;
						pos = 4 * (word + b) + lane;
						// Untouched lanes take anything, touched ones only opaque and strictly deeper
						if (!touched[pos] || (idx != '0 && a[15:14] > level[pos])) begin
							touched[pos] = 1'b1;
							level[pos] = a[15:14];
							data[pos] = {a[20:16], idx};
						end
					end
				end
			end
		end
	end
	for (pos = 0; pos < PixelCount; pos++) begin
		modelPixel[pos] = touched[pos] ? data[pos] : '0;
	end
endfunction

`endif

//--- test/spriteTb.sv
`timescale 1ns/1ps

module spriteTb import spritePkg::*; ();

	localparam int SpriteCount = 8;
	localparam int TileCount = 16;
	localparam int LineWords = 16;
	localparam int PixelCount = LineWords * 4;
	localparam int ScanBits = $clog2(PixelCount);
	localparam int RowCount = TileCount * 8;
	localparam int ApbLimit = 8;
	localparam int DoneLimit = 200;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	apbAddrT paddr;
	apbDataT pwdata;
	apbDataT prdata;
	logic pready;
	logic pslverr;
	logic [ScanBits-1:0] scanAddr;
	pixelT scanPixel;

	// Host side copy of the tables, kept only for writes the DUT accepted
	attrT attrCopy [SpriteCount];
	tileRowT tileCopy [RowCount];
	pixelT scanned [PixelCount];

	logic [15:0] lfsr;
	apbDataT readValue;
	logic errorFlag;
	int errors;
	int checks;
	int timeouts;

	`include "spriteModel.svh"

	spriteTop #(
		.SpriteCount(SpriteCount),
		.TileCount(TileCount),
		.LineWords(LineWords)
	) u_dut (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.scanAddr(scanAddr),
		.scanPixel(scanPixel)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit
	function automatic logic stepLfsr();
		logic feedback;
		feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], feedback};
		return feedback;
	endfunction

	function automatic apbDataT randomBits(input int width);
		apbDataT value;
		int i;
		value = '0;
		for (i = 0; i < width; i++) begin
			value = {value[30:0], stepLfsr()};
		end
		return value;
	endfunction

	function automatic attrT makeAttr(input logic enable, input int tile, input int palette,
		input int depth, input int y, input int x);
		return {enable, 4'(tile), 5'(palette), 2'(depth), 8'(y), 6'(x)};
	endfunction

	task automatic checkValue(input string name, input apbDataT expected, input apbDataT actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	////////////////////
	// APB master, three cycles per transfer including the idle cycle
	task automatic apbAccess(input logic write, input apbAddrT addr, input apbDataT data);
		int waitCount;
		@(posedge clk);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		waitCount = 0;
		@(negedge clk);
		while (!pready && waitCount < ApbLimit) begin
			@(negedge clk);
			waitCount++;
		end
		if (!pready) begin
			timeouts++;
			$display("Timeout: no pready for the access to address %0h", addr);
		end
		// Sampled mid access phase where prdata and pslverr are settled
		readValue = prdata;
		errorFlag = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbWrite(input apbAddrT addr, input apbDataT data);
		apbAccess(1'b1, addr, data);
	endtask

	task automatic apbRead(input apbAddrT addr);
		apbAccess(1'b0, addr, '0);
	endtask

	task automatic writeSprite(input int slot, input attrT attr);
		apbWrite(spriteBase + apbAddrT'(4 * slot), apbDataT'(attr));
		attrCopy[slot] = attr;
	endtask

	task automatic writeTileRow(input int index, input tileRowT row);
		apbWrite(tileBase + apbAddrT'(4 * index), row);
		tileCopy[index] = row;
	endtask

	////////////////////
	// Done polling and the line scan
	// Status is read until the sticky done flag shows up
	task automatic waitDone(input string name);
		int polls;
		polls = 0;
		readValue = '0;
		while (!readValue[1] && polls < DoneLimit) begin
			apbRead(statusAddr);
			polls++;
		end
		if (!readValue[1]) begin
			timeouts++;
			$display("Timeout: the %s compose never reported done", name);
		end
	endtask

	task automatic scanLine();
		int i;
		for (i = 0; i < PixelCount; i++) begin
			@(posedge clk);
			#1;
			scanAddr = ScanBits'(i);
			// The pixel is registered on the following edge
			@(posedge clk);
			@(negedge clk);
			scanned[i] = scanPixel;
		end
	endtask

	task automatic compareLine(input string name);
		int i;
		for (i = 0; i < PixelCount; i++) begin
			checkValue($sformatf("%s pixel %0d", name, i), apbDataT'(modelPixel[i]),
				apbDataT'(scanned[i]));
		end
	endtask

	task automatic composeAndCheck(input string name, input int lineNo);
		apbWrite(lineAddr, apbDataT'(lineNo));
		composeLine(lineNo);
		apbWrite(ctrlAddr, 32'd1);
		waitDone(name);
		scanLine();
		compareLine(name);
	endtask

	////////////////////
	// Test sequence
	initial begin
		int i;
		int pass;
		int lineNo;
		logic enable;
		int tile;
		int palette;
		int depth;
		int y;
		int x;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		scanAddr = '0;
		lfsr = 16'd61101;
		errors = 0;
		checks = 0;
		timeouts = 0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// Register access and the reset state
		apbRead(statusAddr);
		checkValue("reset status", 32'd0, readValue);
		scanLine();
		for (i = 0; i < PixelCount; i++) begin
			checkValue($sformatf("reset pixel %0d", i), 32'd0, apbDataT'(scanned[i]));
		end
		apbWrite(lineAddr, 32'h0000_00a5);
		apbRead(lineAddr);
		checkValue("line readback", 32'h0000_00a5, readValue);
		writeSprite(3, attrT'(randomBits(26)));
		apbRead(spriteBase + 12'h00c);
		checkValue("sprite readback", apbDataT'(attrCopy[3]), readValue);
		checkValue("sprite read pslverr", 32'd0, apbDataT'(errorFlag));
		writeTileRow(77, randomBits(32));
		apbRead(tileBase + apbAddrT'(4 * 77));
		checkValue("tile readback", tileCopy[77], readValue);
		apbRead(12'h00c);
		checkValue("unmapped read pslverr", 32'd1, apbDataT'(errorFlag));
		apbWrite(12'h200, 32'h1234_5678);
		checkValue("unmapped write pslverr", 32'd1, apbDataT'(errorFlag));

		// Random tables over several lines, sprite tops kept near the line for many hits
		for (pass = 0; pass < 4; pass++) begin
			lineNo = int'(randomBits(8));
			for (i = 0; i < RowCount; i++) begin
				writeTileRow(i, randomBits(32));
			end
			for (i = 0; i < SpriteCount; i++) begin
				enable = randomBits(3) != '0;
				tile = int'(randomBits(4));
				palette = int'(randomBits(5));
				depth = int'(randomBits(2));
				y = lineNo - int'(randomBits(4));
				x = int'(randomBits(6));
				writeSprite(i, makeAttr(enable, tile, palette, depth, y, x));
			end
			composeAndCheck($sformatf("random line %0d", lineNo), lineNo);
		end

		// Depth ties, strict priority and transparent pixels on untouched lanes
		writeTileRow(8, 32'h1111_1111);
		writeTileRow(16, 32'h2020_2020);
		writeTileRow(24, 32'h3333_3333);
		writeTileRow(32, 32'h0000_0000);
		writeSprite(0, makeAttr(1'b1, 1, 1, 1, 40, 0));
		writeSprite(1, makeAttr(1'b1, 3, 2, 1, 40, 0));
		writeSprite(2, makeAttr(1'b1, 2, 3, 2, 40, 4));
		writeSprite(3, makeAttr(1'b1, 4, 4, 3, 40, 8));
		writeSprite(4, makeAttr(1'b1, 3, 5, 0, 40, 12));
		writeSprite(5, makeAttr(1'b1, 3, 6, 3, 40, 8));
		writeSprite(6, '0);
		writeSprite(7, '0);
		composeAndCheck("depth", 40);
		checkValue("depth tie pixel 0", 32'h011, apbDataT'(scanned[0]));
		checkValue("depth transparent pixel 4", 32'h011, apbDataT'(scanned[4]));
		checkValue("depth greater pixel 5", 32'h032, apbDataT'(scanned[5]));
		checkValue("depth replace pixel 8", 32'h063, apbDataT'(scanned[8]));
		checkValue("depth untouched pixel 12", 32'h040, apbDataT'(scanned[12]));
		checkValue("depth fresh pixel 16", 32'h053, apbDataT'(scanned[16]));

		// Every offset, in the middle of the line and at the right edge
		writeTileRow(43, 32'h8765_4321);
		writeSprite(0, makeAttr(1'b1, 5, 1, 3, 97, 0));
		writeSprite(1, makeAttr(1'b1, 5, 2, 3, 97, 9));
		writeSprite(2, makeAttr(1'b1, 5, 3, 3, 97, 18));
		writeSprite(3, makeAttr(1'b1, 5, 4, 3, 97, 27));
		writeSprite(4, makeAttr(1'b1, 5, 5, 3, 97, 60));
		writeSprite(5, makeAttr(1'b1, 5, 6, 3, 97, 61));
		writeSprite(6, makeAttr(1'b1, 5, 7, 3, 97, 62));
		writeSprite(7, makeAttr(1'b1, 5, 8, 3, 97, 63));
		composeAndCheck("offset", 100);
		checkValue("offset leftover pixel 16", 32'h028, apbDataT'(scanned[16]));
		checkValue("offset leftover pixel 34", 32'h048, apbDataT'(scanned[34]));
		checkValue("offset edge pixel 63", 32'h054, apbDataT'(scanned[63]));

		// Writes during a compose are refused and a second start is dropped
		composeLine(100);
		apbWrite(ctrlAddr, 32'd1);
		apbWrite(spriteBase, 32'd0);
		checkValue("lock sprite pslverr", 32'd1, apbDataT'(errorFlag));
		apbWrite(tileBase + apbAddrT'(4 * 43), 32'd0);
		checkValue("lock tile pslverr", 32'd1, apbDataT'(errorFlag));
		apbWrite(lineAddr, 32'd7);
		checkValue("lock line pslverr", 32'd1, apbDataT'(errorFlag));
		apbWrite(ctrlAddr, 32'd1);
		checkValue("lock restart pslverr", 32'd0, apbDataT'(errorFlag));
		waitDone("lock");
		apbRead(statusAddr);
		checkValue("lock single done", 32'd0, readValue);
		apbRead(spriteBase);
		checkValue("lock sprite kept", apbDataT'(attrCopy[0]), readValue);
		apbRead(tileBase + apbAddrT'(4 * 43));
		checkValue("lock tile kept", tileCopy[43], readValue);
		apbRead(lineAddr);
		checkValue("lock line kept", 32'd100, readValue);
		scanLine();
		compareLine("lock");

		$display("Checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
